/* verilog/tft_pkg.sv */
package tft_pkg;

    // Horizontal timing in pixel clocks
    localparam int hsync_len  = 2;
    localparam int hback_len  = 3;
    localparam int hdisp_len  = 8;
    localparam int hfront_len = 2;

    // Vertical timing in lines
    localparam int vsync_len  = 1;
    localparam int vback_len  = 3;
    localparam int vdisp_len  = 4;
    localparam int vfront_len = 1;

    // Sync overlaps the back porch, so it is not part of the totals
    localparam int htotal = hback_len + hdisp_len + hfront_len;
    localparam int vtotal = vback_len + vdisp_len + vfront_len;

    localparam int pix_width    = 24;
    localparam int frame_pixels = hdisp_len * vdisp_len;
    localparam int fifo_depth   = 16;

    typedef logic [pix_width-1:0]                pixel_t;
    typedef logic [$clog2(frame_pixels)-1:0]     pix_addr_t;
    typedef logic [$clog2(fifo_depth):0]         fifo_count_t;
    typedef logic [$clog2(fifo_depth)-1:0]       fifo_ptr_t;
    typedef logic [$clog2(htotal)-1:0]           hcount_t;
    typedef logic [$clog2(vtotal)-1:0]           vcount_t;

    typedef enum logic [1:0] {
        wait_vsync,
        filling,
        done
    } fetch_state_t;

endpackage

/* verilog/frame_ram.sv */
`timescale 1ns/1ns

module frame_ram (
    input  logic               CLK,
    input  logic               mem_en,
    input  logic               mem_we,
    input  tft_pkg::pix_addr_t mem_addr,
    input  tft_pkg::pixel_t    mem_wdata,
    output tft_pkg::pixel_t    mem_rdata
);
    import tft_pkg::*;

    pixel_t mem [frame_pixels];

    // Single port, read data one cycle after the enable
    always_ff @(posedge CLK) begin
        if (mem_en) begin
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= mem[mem_addr];
            end
        end
    end

endmodule

/* verilog/ram_arbiter.sv */
`timescale 1ns/1ns

module ram_arbiter (
    input  logic               CLK,
    input  logic               RESET_IN,
    input  logic               wr_stb,
    input  tft_pkg::pix_addr_t wr_addr,
    input  tft_pkg::pixel_t    wr_data,
    input  logic               rd_req,
    input  tft_pkg::pix_addr_t rd_addr,
    input  tft_pkg::pixel_t    mem_rdata,
    output logic               rd_gnt,
    output logic               rd_valid,
    output tft_pkg::pixel_t    rd_data,
    output logic               mem_en,
    output logic               mem_we,
    output tft_pkg::pix_addr_t mem_addr,
    output tft_pkg::pixel_t    mem_wdata
);

    // Host strobe cannot wait, so it always wins
    assign rd_gnt = rd_req & ~wr_stb;

    assign mem_en    = wr_stb | rd_gnt;
    assign mem_we    = wr_stb;
    assign mem_addr  = wr_stb ? wr_addr : rd_addr;
    assign mem_wdata = wr_data;

    // Read data comes back a cycle after the grant
    always_ff @(posedge CLK or posedge RESET_IN) begin
        if (RESET_IN) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_gnt;
        end
    end

    assign rd_data = mem_rdata;

endmodule

/* verilog/pixel_fifo.sv */
`timescale 1ns/1ns

module pixel_fifo (
    input  logic                 CLK,
    input  logic                 RESET_IN,
    input  logic                 push,
    input  tft_pkg::pixel_t      push_data,
    input  logic                 ack,
    output logic                 req,
    output tft_pkg::pixel_t      data,
    output tft_pkg::fifo_count_t count
);
    import tft_pkg::*;

    pixel_t    mem [fifo_depth];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    logic      do_push;
    logic      do_pop;

    // Head word is visible before the pop
    assign req  = count != '0;
    assign data = mem[rd_ptr];

    // Pop only when something is there; a push into a full FIFO needs a pop alongside
    assign do_pop  = ack & req;
    assign do_push = push & ((count != fifo_count_t'(fifo_depth)) | do_pop);

    always_ff @(posedge CLK) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge CLK or posedge RESET_IN) begin
        if (RESET_IN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog/scanout_fetch.sv */
`timescale 1ns/1ns

module scanout_fetch (
    input  logic                 CLK,
    input  logic                 RESET_IN,
    input  logic                 vsync_stat,
    input  logic                 rd_gnt,
    input  logic                 rd_valid,
    input  tft_pkg::pixel_t      rd_data,
    input  tft_pkg::fifo_count_t count,
    output logic                 rd_req,
    output tft_pkg::pix_addr_t   rd_addr,
    output logic                 push,
    output tft_pkg::pixel_t      push_data
);
    import tft_pkg::*;

    fetch_state_t               state;
    fifo_count_t                inflight;
    logic [$bits(fifo_count_t):0] pending;
    logic                       vsync_d;

    // FIFO words plus reads not yet returned
    assign pending = count + inflight;
    assign rd_req  = (state == filling) && !vsync_stat && (pending < fifo_depth);

    always_ff @(posedge CLK or posedge RESET_IN) begin
        if (RESET_IN) begin
            state   <= wait_vsync;
            rd_addr <= '0;
            vsync_d <= 1'b0;
        end else begin
            vsync_d <= vsync_stat;
            if (vsync_stat) begin
                state   <= wait_vsync;
                rd_addr <= '0;
            end else begin
                case (state)
                    wait_vsync: begin
                        if (vsync_d) begin
                            state <= filling;
                        end
                    end
                    filling: begin
                        if (rd_gnt) begin
                            rd_addr <= rd_addr + 1'b1;
                            if (rd_addr == pix_addr_t'(frame_pixels - 1)) begin
                                state <= done;
                            end
                        end
                    end
                    default: state <= done;
                endcase
            end
        end
    end

    // Outstanding reads, kept across vsync so late returns stay counted
    always_ff @(posedge CLK or posedge RESET_IN) begin
        if (RESET_IN) begin
            inflight <= '0;
        end else begin
            case ({rd_gnt, rd_valid})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
        end
    end

    assign push      = rd_valid;
    assign push_data = rd_data;

endmodule

/* verilog/tft_io.sv */
`timescale 1ns/1ns

module tft_io (
    input  logic            CLK,
    input  logic            RESET_IN,
    input  tft_pkg::pixel_t data,
    input  logic            req,
    output logic            ack,
    output logic            underflow,
    output logic            vsync_stat,
    output logic            tft_dclk,
    output logic            tft_disp,
    output logic            tft_hsync,
    output logic            tft_vsync,
    output tft_pkg::pixel_t tft_rgb
);
    import tft_pkg::*;

    logic    enable_tft;
    hcount_t hcnt;
    vcount_t vcnt;
    logic    hsync;
    logic    vsync;
    logic    disp;

    // Panel is enabled one cycle after reset is released
    always_ff @(posedge CLK or posedge RESET_IN) begin
        if (RESET_IN) begin
            enable_tft <= 1'b0;
        end else begin
            enable_tft <= 1'b1;
        end
    end

    assign tft_dclk = CLK;
    assign tft_disp = enable_tft;

    // Line position, counts down and reloads at zero
    always_ff @(posedge CLK or posedge RESET_IN) begin
        if (RESET_IN) begin
            hcnt <= '0;
        end else if (hcnt != '0) begin
            hcnt <= hcnt - 1'b1;
        end else if (enable_tft) begin
            hcnt <= hcount_t'(htotal - 1);
        end
    end

    // Frame position, steps once per line
    always_ff @(posedge CLK or posedge RESET_IN) begin
        if (RESET_IN) begin
            vcnt <= '0;
        end else if (hcnt == '0) begin
            if (vcnt != '0) begin
                vcnt <= vcnt - 1'b1;
            end else if (enable_tft) begin
                vcnt <= vcount_t'(vtotal - 1);
            end
        end
    end

    // Sync starts at the reload, the window follows the back porch
    assign hsync = hcnt >= htotal - hsync_len;
    assign vsync = vcnt >= vtotal - vsync_len;
    assign disp  = (hcnt >= htotal - hback_len - hdisp_len) && (hcnt < htotal - hback_len) &&
                   (vcnt >= vtotal - vback_len - vdisp_len) && (vcnt < vtotal - vback_len);

    // Pop while displaying, and flush leftovers during vsync
    assign ack = vsync_stat | disp;

    // Sticky until reset
    always_ff @(posedge CLK or posedge RESET_IN) begin
        if (RESET_IN) begin
            underflow <= 1'b0;
        end else if (disp && !req) begin
            underflow <= 1'b1;
        end
    end

    // Pin outputs, sync pins are active low
    always_ff @(posedge CLK or posedge RESET_IN) begin
        if (RESET_IN) begin
            tft_hsync  <= 1'b1;
            tft_vsync  <= 1'b1;
            vsync_stat <= 1'b0;
        end else begin
            tft_hsync  <= ~hsync;
            tft_vsync  <= ~vsync;
            vsync_stat <= vsync;
        end
    end

    always_ff @(posedge CLK) begin
        tft_rgb <= data;
    end

endmodule

/* verilog/tft_subsystem.sv */
`timescale 1ns/1ns

module tft_subsystem (
    input  logic               CLK,
    input  logic               RESET_IN,
    input  logic               wr_stb,
    input  tft_pkg::pix_addr_t wr_addr,
    input  tft_pkg::pixel_t    wr_data,
    output logic               tft_dclk,
    output logic               tft_disp,
    output logic               tft_hsync,
    output logic               tft_vsync,
    output tft_pkg::pixel_t    tft_rgb,
    output logic               underflow
);
    import tft_pkg::*;

    // Fetcher to arbiter
    logic        rd_req;
    logic        rd_gnt;
    logic        rd_valid;
    pix_addr_t   rd_addr;
    pixel_t      rd_data;

    // Arbiter to frame memory
    logic        mem_en;
    logic        mem_we;
    pix_addr_t   mem_addr;
    pixel_t      mem_wdata;
    pixel_t      mem_rdata;

    // Pixel FIFO
    logic        push;
    pixel_t      push_data;
    fifo_count_t count;
    logic        req;
    logic        ack;
    pixel_t      data;

    logic        vsync_stat;

    ram_arbiter u_ram_arbiter (
        .CLK       (CLK),
        .RESET_IN  (RESET_IN),
        .wr_stb    (wr_stb),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .mem_rdata (mem_rdata),
        .rd_gnt    (rd_gnt),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    frame_ram u_frame_ram (
        .CLK       (CLK),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    scanout_fetch u_scanout_fetch (
        .CLK        (CLK),
        .RESET_IN   (RESET_IN),
        .vsync_stat (vsync_stat),
        .rd_gnt     (rd_gnt),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .count      (count),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .push       (push),
        .push_data  (push_data)
    );

    pixel_fifo u_pixel_fifo (
        .CLK       (CLK),
        .RESET_IN  (RESET_IN),
        .push      (push),
        .push_data (push_data),
        .ack       (ack),
        .req       (req),
        .data      (data),
        .count     (count)
    );

    tft_io u_tft_io (
        .CLK        (CLK),
        .RESET_IN   (RESET_IN),
        .data       (data),
        .req        (req),
        .ack        (ack),
        .underflow  (underflow),
        .vsync_stat (vsync_stat),
        .tft_dclk   (tft_dclk),
        .tft_disp   (tft_disp),
        .tft_hsync  (tft_hsync),
        .tft_vsync  (tft_vsync),
        .tft_rgb    (tft_rgb)
    );

endmodule

/* bench/tft_checker.sv */
`timescale 1ns/1ns

module tft_checker (
    input  logic               CLK,
    input  logic               RESET_IN,
    input  logic               wr_stb,
    input  tft_pkg::pix_addr_t wr_addr,
    input  tft_pkg::pixel_t    wr_data,
    input  logic               tft_dclk,
    input  logic               tft_disp,
    input  logic               tft_hsync,
    input  logic               tft_vsync,
    input  tft_pkg::pixel_t    tft_rgb,
    input  logic               underflow,
    input  logic               check_pix,
    input  logic               uflow_ok,
    output int                 pix_errs,
    output int                 sync_errs,
    output int                 misc_errs
);
    import tft_pkg::*;

    // Shadow memory holding the current value and the value at the frame start
    pixel_t    cur_val   [frame_pixels];
    pixel_t    start_val [frame_pixels];
    // Writes seen since the frame start
    pix_addr_t wq_addr [$];
    pixel_t    wq_data [$];

    logic      pend_stb = 1'b0;
    pix_addr_t pend_addr;
    pixel_t    pend_data;
    logic      clk_seen = 1'b0;

    logic hs_d = 1'b1;
    logic vs_d = 1'b1;
    logic uf_d = 1'b0;
    logic disp_seen = 1'b0;
    logic uf_reported = 1'b0;
    logic have_start = 1'b0;
    int   hper = -1;
    int   hlow = 0;
    int   vper = -1;
    int   vlow = 0;
    int   line = -1;
    int   hoff = -1;
    int   pix_cnt = 0;
    int   sync_cnt = 0;
    int   misc_cnt = 0;
    int   dclk_cnt = 0;

    assign pix_errs  = pix_cnt;
    assign sync_errs = sync_cnt;
    assign misc_errs = misc_cnt + dclk_cnt;

    function automatic bit written_this_frame(input int a, input pixel_t v);
        bit found;
        found = 1'b0;
        for (int i = 0; i < wq_addr.size(); i++) begin
            if (int'(wq_addr[i]) == a && wq_data[i] === v) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t %s: got %b expected %b", $time, name, got, exp);
            misc_cnt++;
        end
    endtask

    // Capture the write the memory takes at this edge
    always @(posedge CLK) begin
        clk_seen  <= 1'b1;
        pend_stb  <= wr_stb & ~RESET_IN;
        pend_addr <= wr_addr;
        pend_data <= wr_data;
    end

    // Panel clock follows the system clock in both phases
    always @(CLK) begin
        #1;
        if (tft_dclk !== CLK) begin
            $display("ERROR %0t tft_dclk: got %b expected %b", $time, tft_dclk, CLK);
            dclk_cnt++;
        end
    end

    always @(negedge CLK) begin
        int  a;
        logic hs_fall;
        logic hs_rise;
        logic vs_fall;
        logic vs_rise;
        hs_fall = hs_d & ~tft_hsync;
        hs_rise = ~hs_d & tft_hsync;
        vs_fall = vs_d & ~tft_vsync;
        vs_rise = ~vs_d & tft_vsync;
        if (RESET_IN) begin
            if (clk_seen) begin
                check_level("tft_hsync", tft_hsync, 1'b1);
                check_level("tft_vsync", tft_vsync, 1'b1);
                check_level("underflow", underflow, 1'b0);
                check_level("tft_disp", tft_disp, 1'b0);
            end
            for (int i = 0; i < frame_pixels; i++) begin
                cur_val[i]   = '0;
                start_val[i] = '0;
            end
            wq_addr.delete();
            wq_data.delete();
            hs_d = 1'b1;
            vs_d = 1'b1;
            hper = -1;
            vper = -1;
            line = -1;
            hoff = -1;
        end else begin
            if (pend_stb) begin
                cur_val[pend_addr] = pend_data;
                wq_addr.push_back(pend_addr);
                wq_data.push_back(pend_data);
            end
            if (vs_rise) begin
                start_val  = cur_val;
                have_start = 1'b1;
                wq_addr.delete();
                wq_data.delete();
            end

            if (tft_disp === 1'b1) begin
                disp_seen = 1'b1;
            end else if (disp_seen) begin
                $display("ERROR %0t tft_disp: got %b expected 1", $time, tft_disp);
                misc_cnt++;
            end

            // Horizontal sync width and period
            if (hper >= 0) hper++;
            if (hs_fall) begin
                if (hper >= 0 && hper != htotal) begin
                    $display("ERROR %0t tft_hsync period: got %0d expected %0d",
                             $time, hper, htotal);
                    sync_cnt++;
                end
                hper = 0;
                hlow = 0;
            end
            if (!tft_hsync) hlow++;
            if (hs_rise && hper >= 0 && hlow != hsync_len) begin
                $display("ERROR %0t tft_hsync width: got %0d expected %0d",
                         $time, hlow, hsync_len);
                sync_cnt++;
            end

            // Vertical sync width and period in cycles
            if (vper >= 0) vper++;
            if (vs_fall) begin
                if (vper >= 0 && vper != vtotal * htotal) begin
                    $display("ERROR %0t tft_vsync period: got %0d expected %0d",
                             $time, vper, vtotal * htotal);
                    sync_cnt++;
                end
                vper = 0;
                vlow = 0;
            end
            if (!tft_vsync) vlow++;
            if (vs_rise && vper >= 0 && vlow != vsync_len * htotal) begin
                $display("ERROR %0t tft_vsync width: got %0d expected %0d",
                         $time, vlow, vsync_len * htotal);
                sync_cnt++;
            end

            // Position within the frame
            if (hs_fall) begin
                if (vs_fall) begin
                    line = 0;
                end else if (line >= 0) begin
                    line++;
                end
                hoff = 0;
            end else if (hoff >= 0) begin
                hoff++;
            end

            if (check_pix && have_start && line >= vback_len &&
                line < vback_len + vdisp_len && hoff >= hback_len &&
                hoff < hback_len + hdisp_len) begin
                a = (line - vback_len) * hdisp_len + (hoff - hback_len);
                if (tft_rgb !== start_val[a] && !written_this_frame(a, tft_rgb)) begin
                    $display("ERROR %0t tft_rgb at address %0d: got %h expected %h",
                             $time, a, tft_rgb, start_val[a]);
                    pix_cnt++;
                end
            end

            // Underflow is sticky and only allowed once the fetcher starves
            if (underflow === 1'b1 && !uflow_ok && !uf_reported) begin
                $display("ERROR %0t underflow: got 1 expected 0", $time);
                misc_cnt++;
                uf_reported = 1'b1;
            end
            if (uf_d && underflow !== 1'b1) begin
                $display("ERROR %0t underflow: got %b expected 1", $time, underflow);
                misc_cnt++;
            end

            hs_d = tft_hsync;
            vs_d = tft_vsync;
            uf_d = (underflow === 1'b1);
        end
    end

endmodule

/* bench/tb_tft.sv */
`timescale 1ns/1ns

module tb_tft;
    import tft_pkg::*;

    logic      CLK;
    logic      RESET_IN;
    logic      wr_stb;
    pix_addr_t wr_addr;
    pixel_t    wr_data;
    logic      tft_dclk;
    logic      tft_disp;
    logic      tft_hsync;
    logic      tft_vsync;
    pixel_t    tft_rgb;
    logic      underflow;
    logic      check_pix;
    logic      uflow_ok;
    int        pix_errs;
    int        sync_errs;
    int        misc_errs;

    int          tb_errs = 0;
    bit          timed_out = 1'b0;
    logic [31:0] seed = 32'h503f6b13;

    tft_subsystem u_tft_subsystem (
        .CLK       (CLK),
        .RESET_IN  (RESET_IN),
        .wr_stb    (wr_stb),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .tft_dclk  (tft_dclk),
        .tft_disp  (tft_disp),
        .tft_hsync (tft_hsync),
        .tft_vsync (tft_vsync),
        .tft_rgb   (tft_rgb),
        .underflow (underflow)
    );

    tft_checker u_tft_checker (
        .CLK       (CLK),
        .RESET_IN  (RESET_IN),
        .wr_stb    (wr_stb),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .tft_dclk  (tft_dclk),
        .tft_disp  (tft_disp),
        .tft_hsync (tft_hsync),
        .tft_vsync (tft_vsync),
        .tft_rgb   (tft_rgb),
        .underflow (underflow),
        .check_pix (check_pix),
        .uflow_ok  (uflow_ok),
        .pix_errs  (pix_errs),
        .sync_errs (sync_errs),
        .misc_errs (misc_errs)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic wait_for_disp();
        int cycles;
        cycles = 0;
        while (!timed_out && tft_disp !== 1'b1) begin
            @(negedge CLK);
            cycles++;
            if (cycles > 16) begin
                $display("Display enable never came up after reset");
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic fill_memory();
        for (int a = 0; a < frame_pixels; a++) begin
            @(negedge CLK);
            seed    = lcg_next(seed);
            wr_stb  = 1'b1;
            wr_addr = pix_addr_t'(a);
            wr_data = seed[31:8];
        end
        @(negedge CLK);
        wr_stb = 1'b0;
    endtask

    // Host traffic is none in mode 0, one write in four cycles in mode 1
    // and a write every cycle in mode 2
    task automatic run_frames(input int frames, input int mode);
        int   seen;
        int   cycles;
        int   limit;
        logic vs_prev;
        logic strobe;
        seen    = 0;
        cycles  = 0;
        limit   = (frames + 1) * vtotal * htotal;
        vs_prev = tft_vsync;
        while (!timed_out && seen < frames) begin
            @(negedge CLK);
            cycles++;
            if (tft_vsync && !vs_prev) seen++;
            vs_prev = tft_vsync;
            seed    = lcg_next(seed);
            strobe  = (mode == 2) || (mode == 1 && seed[29:28] == 2'b00);
            seed    = lcg_next(seed);
            wr_addr = pix_addr_t'(seed[31:27]);
            seed    = lcg_next(seed);
            wr_data = seed[31:8];
            wr_stb  = strobe;
            if (cycles > limit) begin
                $display("Frame start did not arrive in time");
                timed_out = 1'b1;
            end
        end
        wr_stb = 1'b0;
    endtask

    initial begin
        RESET_IN  = 1'b1;
        wr_stb    = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        check_pix = 1'b0;
        uflow_ok  = 1'b0;
        repeat (8) @(negedge CLK);
        RESET_IN = 1'b0;
        wait_for_disp();
        fill_memory();
        run_frames(3, 0);
        // Static image followed by live writes
        check_pix = 1'b1;
        run_frames(2, 0);
        run_frames(6, 1);
        run_frames(1, 0);
        check_pix = 1'b0;
        // Starve the fetcher
        uflow_ok = 1'b1;
        run_frames(3, 2);
        if (!timed_out && underflow !== 1'b1) begin
            $display("ERROR %0t underflow: got %b expected 1", $time, underflow);
            tb_errs++;
        end
        run_frames(1, 0);
        $display("Errors: pixel %0d, sync %0d, checker other %0d, testbench %0d",
                 pix_errs, sync_errs, misc_errs, tb_errs);
        if (!timed_out && pix_errs + sync_errs + misc_errs + tb_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* files.f */
verilog/tft_pkg.sv
verilog/frame_ram.sv
verilog/ram_arbiter.sv
verilog/pixel_fifo.sv
verilog/scanout_fetch.sv
verilog/tft_io.sv
verilog/tft_subsystem.sv
bench/tft_checker.sv
bench/tb_tft.sv

/* run.sh */
#!/bin/sh
# Build and run the panel testbench, pass or fail comes from the log
rm -f sim.log
verilator --binary --timing --top-module tb_tft -f files.f -o tb_tft_sim \
    && ./obj_dir/tb_tft_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
    && echo "simulation log reports a pass" \
    || { echo "simulation log reports a failure"; exit 1; }
